/* hw/mont_pkg.sv */
package mont_pkg;

    // operand geometry
    localparam int OPERAND_WIDTH = 128;
    localparam int DIGIT_BITS = 2;
    localparam int NUM_DIGITS = OPERAND_WIDTH / DIGIT_BITS;

    // accumulator holds up to 3M plus carry and sign headroom
    localparam int ACC_WIDTH = OPERAND_WIDTH + 4;

    // adder works on one slice per cycle, ACC_WIDTH is an exact multiple
    localparam int ADD_CHUNK_WIDTH = 33;
    localparam int ADD_CHUNKS = ACC_WIDTH / ADD_CHUNK_WIDTH;
    localparam int ADD_IDX_WIDTH = $clog2(ADD_CHUNKS);

    // counts 0 .. NUM_DIGITS
    localparam int ITER_COUNT_WIDTH = $clog2(NUM_DIGITS + 1);

    // second adder operand taken from the multiple table
    typedef enum logic [2:0] {
        SEL_ZERO,
        SEL_B1,
        SEL_B2,
        SEL_B3,
        SEL_M1,
        SEL_M2,
        SEL_M3
    } multiple_sel_e;

    // datapath operation requested by the controller
    typedef enum logic [3:0] {
        OP_IDLE,
        OP_LOAD,
        OP_PRE_B3,
        OP_PRE_M3,
        OP_ADD_DIGIT,
        OP_ADD_QUOT,
        OP_SHIFT,
        OP_SUB_M,
        OP_FINISH
    } dp_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE_B,
        ST_PRE_M,
        ST_DIGIT,
        ST_QUOT,
        ST_SHIFT,
        ST_REDUCE,
        ST_DONE
    } mont_state_e;

endpackage

/* hw/chunked_adder.sv */
module chunked_adder (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           start,
    input  logic                           subtract,
    input  logic [mont_pkg::ACC_WIDTH-1:0] op_a,
    input  logic [mont_pkg::ACC_WIDTH-1:0] op_b,
    output logic [mont_pkg::ACC_WIDTH-1:0] sum,
    output logic                           done
);
    import mont_pkg::*;

    logic [ACC_WIDTH-1:0]       a_q;
    logic [ACC_WIDTH-1:0]       b_q;
    logic [ACC_WIDTH-1:0]       b_eff;
    logic                       carry_q;
    logic                       busy;
    logic [ADD_IDX_WIDTH-1:0]   chunk_idx;
    logic [ADD_CHUNK_WIDTH-1:0] slice_a;
    logic [ADD_CHUNK_WIDTH-1:0] slice_b;
    logic                       carry_in;
    logic [ADD_CHUNK_WIDTH:0]   slice_sum;

    // two's complement subtract, invert here and force carry-in
    assign b_eff = subtract ? ~op_b : op_b;

    // chunk 0 comes straight from the ports in the start cycle
    assign slice_a = start ? op_a[ADD_CHUNK_WIDTH-1:0] : a_q[ADD_CHUNK_WIDTH-1:0];
    assign slice_b = start ? b_eff[ADD_CHUNK_WIDTH-1:0] : b_q[ADD_CHUNK_WIDTH-1:0];
    assign carry_in = start ? subtract : carry_q;
    assign slice_sum = {1'b0, slice_a} + {1'b0, slice_b} + {{ADD_CHUNK_WIDTH{1'b0}}, carry_in};

    // operands shift down one slice per cycle, sum fills in from the top
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= op_a >> ADD_CHUNK_WIDTH;
            b_q <= b_eff >> ADD_CHUNK_WIDTH;
        end else if (busy) begin
            a_q <= a_q >> ADD_CHUNK_WIDTH;
            b_q <= b_q >> ADD_CHUNK_WIDTH;
        end
        if (start || busy) begin
            carry_q <= slice_sum[ADD_CHUNK_WIDTH];
            sum <= {slice_sum[ADD_CHUNK_WIDTH-1:0], sum[ACC_WIDTH-1:ADD_CHUNK_WIDTH]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            chunk_idx <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                chunk_idx <= ADD_IDX_WIDTH'(1);
            end else if (busy) begin
                chunk_idx <= chunk_idx + 1'b1;
                // last slice written on this edge
                if (chunk_idx == ADD_IDX_WIDTH'(ADD_CHUNKS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!resetn) start |-> !busy
    );

endmodule

/* hw/multiple_table.sv */
module multiple_table (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               load_base,
    input  logic                               load_b3,
    input  logic                               load_m3,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] b_in,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] m_in,
    input  logic [mont_pkg::ACC_WIDTH-1:0]     sum_in,
    input  mont_pkg::multiple_sel_e            sel,
    output logic [mont_pkg::ACC_WIDTH-1:0]     multiple,
    output logic [1:0]                         m_low
);
    import mont_pkg::*;

    logic [ACC_WIDTH-1:0] b_ext;
    logic [ACC_WIDTH-1:0] m_ext;
    logic [ACC_WIDTH-1:0] b1_q;
    logic [ACC_WIDTH-1:0] b2_q;
    logic [ACC_WIDTH-1:0] b3_q;
    logic [ACC_WIDTH-1:0] m1_q;
    logic [ACC_WIDTH-1:0] m2_q;
    logic [ACC_WIDTH-1:0] m3_q;

    assign b_ext = {{(ACC_WIDTH - OPERAND_WIDTH){1'b0}}, b_in};
    assign m_ext = {{(ACC_WIDTH - OPERAND_WIDTH){1'b0}}, m_in};

    always_ff @(posedge clk) begin
        // doubles are a plain shift
        if (load_base) begin
            b1_q <= b_ext;
            b2_q <= b_ext << 1;
            m1_q <= m_ext;
            m2_q <= m_ext << 1;
        end
        // triples come back from the shared adder
        if (load_b3) begin
            b3_q <= sum_in;
        end
        if (load_m3) begin
            m3_q <= sum_in;
        end
    end

    always_comb begin
        case (sel)
            SEL_B1:  multiple = b1_q;
            SEL_B2:  multiple = b2_q;
            SEL_B3:  multiple = b3_q;
            SEL_M1:  multiple = m1_q;
            SEL_M2:  multiple = m2_q;
            SEL_M3:  multiple = m3_q;
            default: multiple = '0;
        endcase
    end

    // quotient digit selection needs M mod 4
    assign m_low = m1_q[1:0];

    a_sel_legal: assert property (
        @(posedge clk) disable iff (!resetn)
        sel inside {SEL_ZERO, SEL_B1, SEL_B2, SEL_B3, SEL_M1, SEL_M2, SEL_M3}
    );

endmodule

/* hw/mont_datapath.sv */
module mont_datapath (
    input  logic                               clk,
    input  logic                               resetn,
    input  mont_pkg::dp_op_e                   op,
    input  logic                               add_start,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] b,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] m,
    output logic                               add_done,
    output logic                               sub_negative,
    output logic [mont_pkg::OPERAND_WIDTH-1:0] result
);
    import mont_pkg::*;

    logic [ACC_WIDTH-1:0]     acc;
    logic [OPERAND_WIDTH-1:0] a_reg;
    logic [DIGIT_BITS-1:0]    digit;
    logic [DIGIT_BITS-1:0]    acc_low;
    logic [DIGIT_BITS-1:0]    quot;
    logic [1:0]               m_low;
    multiple_sel_e            sel;
    logic [ACC_WIDTH-1:0]     multiple;
    logic [ACC_WIDTH-1:0]     adder_a;
    logic [ACC_WIDTH-1:0]     adder_b;
    logic [ACC_WIDTH-1:0]     sum;
    logic                     subtract;
    logic                     precompute;
    logic                     load_base;
    logic                     load_b3;
    logic                     load_m3;

    assign digit = a_reg[DIGIT_BITS-1:0];
    assign acc_low = acc[DIGIT_BITS-1:0];

    // q makes acc + q*M divisible by 4, M is odd
    always_comb begin
        if (acc_low[0] && (acc_low == m_low)) begin
            quot = 2'd3;
        end else if (acc_low == 2'd2) begin
            quot = 2'd2;
        end else if (acc_low[0]) begin
            quot = 2'd1;
        end else begin
            quot = 2'd0;
        end
    end

    always_comb begin
        case (op)
            OP_PRE_B3:    sel = SEL_B1;
            OP_PRE_M3:    sel = SEL_M1;
            OP_ADD_DIGIT: sel = (digit == 2'd3) ? SEL_B3 :
                                (digit == 2'd2) ? SEL_B2 :
                                (digit == 2'd1) ? SEL_B1 : SEL_ZERO;
            OP_ADD_QUOT:  sel = (quot == 2'd3) ? SEL_M3 :
                                (quot == 2'd2) ? SEL_M2 :
                                (quot == 2'd1) ? SEL_M1 : SEL_ZERO;
            OP_SUB_M:     sel = SEL_M1;
            default:      sel = SEL_ZERO;
        endcase
    end

    // precompute forms X + 2X from one table entry
    assign precompute = (op == OP_PRE_B3) || (op == OP_PRE_M3);
    assign adder_a = precompute ? multiple : acc;
    assign adder_b = precompute ? (multiple << 1) : multiple;
    assign subtract = (op == OP_SUB_M);

    assign load_base = (op == OP_LOAD);
    assign load_b3 = (op == OP_PRE_B3) && add_done;
    assign load_m3 = (op == OP_PRE_M3) && add_done;

    always_ff @(posedge clk) begin
        case (op)
            OP_LOAD: begin
                acc <= '0;
                a_reg <= a;
            end
            OP_ADD_DIGIT, OP_ADD_QUOT: begin
                if (add_done) begin
                    acc <= sum;
                end
            end
            OP_SHIFT: begin
                acc <= acc >> DIGIT_BITS;
                a_reg <= a_reg >> DIGIT_BITS;
            end
            OP_SUB_M: begin
                if (add_done) begin
                    sub_negative <= sum[ACC_WIDTH-1];
                end
            end
            // adder still holds acc - M here
            OP_FINISH: begin
                result <= sub_negative ? acc[OPERAND_WIDTH-1:0] : sum[OPERAND_WIDTH-1:0];
            end
            default: begin
            end
        endcase
    end

    chunked_adder u_adder (
        .clk      (clk),
        .resetn   (resetn),
        .start    (add_start),
        .subtract (subtract),
        .op_a     (adder_a),
        .op_b     (adder_b),
        .sum      (sum),
        .done     (add_done)
    );

    multiple_table u_table (
        .clk       (clk),
        .resetn    (resetn),
        .load_base (load_base),
        .load_b3   (load_b3),
        .load_m3   (load_m3),
        .b_in      (b),
        .m_in      (m),
        .sum_in    (sum),
        .sel       (sel),
        .multiple  (multiple),
        .m_low     (m_low)
    );

endmodule

/* hw/mont_controller.sv */
module mont_controller (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic             add_done,
    input  logic             sub_negative,
    output mont_pkg::dp_op_e op,
    output logic             add_start,
    output logic             done
);
    import mont_pkg::*;

    mont_state_e                 state;
    mont_state_e                 state_next;
    logic [ITER_COUNT_WIDTH-1:0] iter_cnt;
    logic                        step_busy;
    logic                        add_state;
    logic                        last_digit;

    // states that run one adder step each
    assign add_state = (state == ST_PRE_B) || (state == ST_PRE_M) || (state == ST_DIGIT) ||
                       (state == ST_QUOT) || (state == ST_REDUCE);

    // one strobe on the first cycle of each adder step
    assign add_start = add_state && !step_busy;

    assign last_digit = (iter_cnt == ITER_COUNT_WIDTH'(NUM_DIGITS - 1));

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_PRE_B;
                end
            end
            ST_PRE_B: begin
                if (add_done) begin
                    state_next = ST_PRE_M;
                end
            end
            ST_PRE_M: begin
                if (add_done) begin
                    state_next = ST_DIGIT;
                end
            end
            ST_DIGIT: begin
                if (add_done) begin
                    state_next = ST_QUOT;
                end
            end
            ST_QUOT: begin
                if (add_done) begin
                    state_next = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                state_next = last_digit ? ST_REDUCE : ST_DIGIT;
            end
            ST_REDUCE: begin
                if (add_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // operands are sampled in the start cycle itself
    always_comb begin
        case (state)
            ST_IDLE:   op = start ? OP_LOAD : OP_IDLE;
            ST_PRE_B:  op = OP_PRE_B3;
            ST_PRE_M:  op = OP_PRE_M3;
            ST_DIGIT:  op = OP_ADD_DIGIT;
            ST_QUOT:   op = OP_ADD_QUOT;
            ST_SHIFT:  op = OP_SHIFT;
            ST_REDUCE: op = OP_SUB_M;
            ST_DONE:   op = OP_FINISH;
            default:   op = OP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
            iter_cnt <= '0;
            step_busy <= 1'b0;
            done <= 1'b0;
        end else begin
            state <= state_next;
            // result is written at the end of ST_DONE, so done follows it
            done <= (state == ST_DONE);
            if (add_start) begin
                step_busy <= 1'b1;
            end else if (add_done) begin
                step_busy <= 1'b0;
            end
            if ((state == ST_IDLE) && start) begin
                iter_cnt <= '0;
            end else if (state == ST_SHIFT) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    a_done_single_cycle: assert property (
        @(posedge clk) disable iff (!resetn) done |=> !done
    );

    a_iter_in_range: assert property (
        @(posedge clk) disable iff (!resetn) iter_cnt <= ITER_COUNT_WIDTH'(NUM_DIGITS)
    );

    // datapath must have captured the sign before the finish step uses it
    a_sign_known: assert property (
        @(posedge clk) disable iff (!resetn) (state == ST_DONE) |-> !$isunknown(sub_negative)
    );

endmodule

/* hw/montgomery_mult.sv */
module montgomery_mult (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               start,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] a,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] b,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] m,
    output logic [mont_pkg::OPERAND_WIDTH-1:0] result,
    output logic                               done
);
    import mont_pkg::*;

    dp_op_e op;
    logic   add_start;
    logic   add_done;
    logic   sub_negative;

    // sequencing of precompute, digit loop and reduction
    mont_controller u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .add_done     (add_done),
        .sub_negative (sub_negative),
        .op           (op),
        .add_start    (add_start),
        .done         (done)
    );

    // accumulator, multiples and the shared adder
    mont_datapath u_dp (
        .clk          (clk),
        .resetn       (resetn),
        .op           (op),
        .add_start    (add_start),
        .a            (a),
        .b            (b),
        .m            (m),
        .add_done     (add_done),
        .sub_negative (sub_negative),
        .result       (result)
    );

endmodule

/* verification/mont_checker.sv */
module mont_checker (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               done,
    input  logic [mont_pkg::OPERAND_WIDTH-1:0] result
);
    timeunit 1ns;
    timeprecision 1ps;
    import mont_pkg::*;

    // one entry per multiplication that has been started
    logic [OPERAND_WIDTH-1:0] exp_q[$];
    logic [OPERAND_WIDTH-1:0] mod_q[$];
    string                    name_q[$];

    int   pass_count = 0;
    int   fail_count = 0;
    int   open_errors = 0;
    logic done_prev;

    task automatic expect_run(input logic [OPERAND_WIDTH-1:0] expected,
                              input logic [OPERAND_WIDTH-1:0] modulus,
                              input string name);
        exp_q.push_back(expected);
        mod_q.push_back(modulus);
        name_q.push_back(name);
    endtask

    task automatic close_test(input string name);
        if (open_errors == 0) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, open_errors);
        end
        open_errors = 0;
    endtask

    task automatic check_result(input logic [OPERAND_WIDTH-1:0] expected,
                                input logic [OPERAND_WIDTH-1:0] modulus,
                                input string name);
        if (result !== expected) begin
            $display("mismatch at %0t: result expected %h, got %h", $time, expected, result);
            open_errors++;
        end
        // a fully reduced value is below M
        if (result >= modulus) begin
            $display("error at %0t: result %h is not below the modulus %h",
                     $time, result, modulus);
            open_errors++;
        end
        close_test(name);
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            done_prev <= 1'b0;
        end else begin
            done_prev <= done;
            if (done && done_prev) begin
                $display("error at %0t: done stayed high for more than one cycle", $time);
                open_errors++;
            end else if (done) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: done pulsed with no multiplication pending", $time);
                    open_errors++;
                end else begin
                    check_result(exp_q.pop_front(), mod_q.pop_front(), name_q.pop_front());
                end
            end
        end
    end

    task automatic print_summary();
        if (exp_q.size() != 0) begin
            $display("error: %0d multiplication(s) ended without a done pulse", exp_q.size());
            open_errors += exp_q.size();
        end
        if (open_errors != 0) begin
            close_test("end of run");
        end
        $display("summary: %0d tests, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

    function automatic int failures();
        return fail_count;
    endfunction

    function automatic int passes();
        return pass_count;
    endfunction

endmodule

/* verification/tb_montgomery_mult.sv */
module tb_montgomery_mult;
    timeunit 1ns;
    timeprecision 1ps;
    import mont_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 20;
    localparam int MAX_VECTORS = 32;
    // upper bound for one multiplication in cycles
    localparam int RUN_BUDGET = 12 * NUM_DIGITS + 40;

    logic                     clk;
    logic                     resetn;
    logic                     start;
    logic [OPERAND_WIDTH-1:0] a;
    logic [OPERAND_WIDTH-1:0] b;
    logic [OPERAND_WIDTH-1:0] m;
    logic [OPERAND_WIDTH-1:0] result;
    logic                     done;

    // four words per vector: A, B, M, expected
    logic [OPERAND_WIDTH-1:0] tv_mem [0:4*MAX_VECTORS-1];
    int                       num_vectors;
    int                       watchdog_limit;
    integer                   seed;

    montgomery_mult DUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    mont_checker u_checker (
        .clk    (clk),
        .resetn (resetn),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // called on a falling edge, returns on the next one with start low again
    task automatic launch(input int idx, input string name);
        a = tv_mem[4*idx];
        b = tv_mem[4*idx + 1];
        m = tv_mem[4*idx + 2];
        start = 1'b1;
        u_checker.expect_run(tv_mem[4*idx + 3], tv_mem[4*idx + 2], name);
        @(negedge clk);
        start = 1'b0;
    endtask

    // start pulse that the busy DUT must ignore
    task automatic stray_start(input int idx);
        a = tv_mem[4*idx];
        b = tv_mem[4*idx + 1];
        m = tv_mem[4*idx + 2];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic scramble_inputs();
        a = {$random(seed), $random(seed), $random(seed), $random(seed)};
        b = {$random(seed), $random(seed), $random(seed), $random(seed)};
        m = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // watchdog bounds this loop
    task automatic wait_done();
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic run_tests();
        int mid;
        int last;
        mid = num_vectors / 2;
        last = num_vectors - 1;

        repeat (IDLE_CYCLES) @(negedge clk);
        u_checker.close_test("idle after reset");

        for (int i = 0; i < num_vectors; i++) begin
            launch(i, $sformatf("vector %0d", i));
            wait_done();
            repeat (3) @(negedge clk);
        end

        // operands turn to garbage right after the start cycle
        launch(mid, $sformatf("input change, vector %0d", mid));
        scramble_inputs();
        wait_done();
        @(negedge clk);
        launch(last, $sformatf("input change, vector %0d", last));
        scramble_inputs();
        wait_done();
        @(negedge clk);

        launch(last, $sformatf("start while busy, vector %0d", last));
        repeat (40) @(negedge clk);
        stray_start(0);
        repeat (200) @(negedge clk);
        stray_start(mid);
        wait_done();

        // next start lands in the done cycle
        for (int i = 0; i < num_vectors; i++) begin
            launch(i, $sformatf("back to back, vector %0d", i));
            wait_done();
        end

        // a late extra done would show up here
        repeat (RUN_BUDGET) @(negedge clk);
        u_checker.close_test("idle after last run");
    endtask

    initial begin
        resetn = 1'b0;
        start = 1'b0;
        a = '0;
        b = '0;
        m = '0;
        seed = 32'h8769;
        num_vectors = 0;
        watchdog_limit = 0;
        for (int i = 0; i < 4*MAX_VECTORS; i++) begin
            tv_mem[i] = '0;
        end
        $readmemh("verification/montgomery_testdata.hex", tv_mem);
        // M is odd, so a zero modulus marks the end of the vectors
        while ((num_vectors < MAX_VECTORS) && (tv_mem[4*num_vectors + 2] != '0)) begin
            num_vectors++;
        end
        // 2n+3 multiplications plus the closing idle window
        watchdog_limit = RESET_CYCLES + IDLE_CYCLES + (2*num_vectors + 4) * RUN_BUDGET;

        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;

        if (num_vectors == 0) begin
            $display("error: no test vectors were read from the data file");
        end else begin
            run_tests();
        end

        u_checker.print_summary();
        if ((num_vectors > 0) && (u_checker.failures() == 0) && (u_checker.passes() > 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_limit > 0);
        repeat (watchdog_limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* montgomery_mult.f */
hw/mont_pkg.sv
hw/chunked_adder.sv
hw/multiple_table.sv
hw/mont_datapath.sv
hw/mont_controller.sv
hw/montgomery_mult.sv
verification/mont_checker.sv
verification/tb_montgomery_mult.sv

/* Bender.yml */
package:
  name: montgomery_mult

sources:
  - files:
      - hw/mont_pkg.sv
      - hw/chunked_adder.sv
      - hw/multiple_table.sv
      - hw/mont_datapath.sv
      - hw/mont_controller.sv
      - hw/montgomery_mult.sv
  - target: test
    files:
      - verification/mont_checker.sv
      - verification/tb_montgomery_mult.sv

/* verification/montgomery_testdata.hex */
// columns: A B M expected, 128-bit hex words, expected = A*B*2^-128 mod M
// moduli 2^128-1, 2^128-3, 2^127+1 and 2^127+3 cover M mod 4 of both 1 and 3
00000000000000000000000000000000 0123456789abcdef0fedcba987654321 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000
fffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffe ffffffffffffffffffffffffffffffff 00000000000000000000000000000001
0123456789abcdef0011223344556677 00000000000000000000000000000010 ffffffffffffffffffffffffffffffff 123456789abcdef00112233445566770
fedcba9876543210aa55aa55c3c3c3c3 00000000000000010000000000000000 ffffffffffffffffffffffffffffffff aa55aa55c3c3c3c3fedcba9876543210
8badf00ddeadbeefcafebabe12345678 00000000000000000000000000000001 ffffffffffffffffffffffffffffffff 8badf00ddeadbeefcafebabe12345678
00000000000000000000000000000003 0f1e2d3c4b5a69788796a5b4c3d2e1f0 fffffffffffffffffffffffffffffffd 0f1e2d3c4b5a69788796a5b4c3d2e1f0
fffffffffffffffffffffffffffffffc 00000000000000000000000000000003 fffffffffffffffffffffffffffffffd fffffffffffffffffffffffffffffffc
00000000000000000000000000000003 fffffffffffffffffffffffffffffffc fffffffffffffffffffffffffffffffd fffffffffffffffffffffffffffffffc
7fffffffffffffffffffffffffffffff 13579bdf2468ace013579bdf2468ace0 80000000000000000000000000000001 13579bdf2468ace013579bdf2468ace0
6a09e667f3bcc908b2fb1366ea957d3e 7fffffffffffffffffffffffffffffff 80000000000000000000000000000001 6a09e667f3bcc908b2fb1366ea957d3e
7ffffffffffffffffffffffffffffffd 3c6ef372fe94f82ba54ff53a5f1d36f1 80000000000000000000000000000003 3c6ef372fe94f82ba54ff53a5f1d36f1
510e527fade682d19b05688c2b3e6c1f 7ffffffffffffffffffffffffffffffd 80000000000000000000000000000003 510e527fade682d19b05688c2b3e6c1f
